// ==== hw/deser_pkg.sv ====
// Shared types and width helpers for the narrow-to-wide packet link receiver
package deser_pkg;

  // ------------------------------
  // Packet metadata sideband
  // ------------------------------

  // Metadata travels next to every flit and is sampled on the completing flit
  localparam int META_WIDTH = 3;

  typedef logic [META_WIDTH-1:0] meta_t;

  // ------------------------------
  // Pop-side skid register states
  // ------------------------------

  // The state counts how many wide words the skid register currently holds
  typedef enum logic [1:0] {
    SKID_EMPTY = 2'd0,
    SKID_ONE   = 2'd1,
    SKID_TWO   = 2'd2
  } skid_state_t;

  // ------------------------------
  // Width helpers
  // ------------------------------

  // Width of the flit-id counter and of the don't-care count for a given ratio
  // A ratio of 1 still needs one bit, since a vector cannot be zero bits wide
  function automatic int flit_id_width(input int ratio);
    return (ratio > 1) ? $clog2(ratio) : 1;
  endfunction

endpackage : deser_pkg

// ==== hw/flit_id_counter.sv ====
// Position counter of the next push flit inside the wide flit under construction
`timescale 1ns/100ps

module flit_id_counter import deser_pkg::*; #(
  parameter int PushWidth = 8,
  parameter int PopWidth  = 32
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  // One push flit was accepted without completing the wide flit
  input  logic                                        advance,
  // The wide flit left on the pop side, so the next push starts at slice 0
  input  logic                                        reinit,
  output logic [flit_id_width(PopWidth/PushWidth)-1:0] flit_id
);

  localparam int Ratio       = PopWidth / PushWidth;
  localparam int FlitIdWidth = flit_id_width(Ratio);
  localparam int RatioMinus1 = Ratio - 1;

  logic at_max;

  // The last slice is never registered, so the count stops there
  assign at_max = (flit_id == FlitIdWidth'(RatioMinus1));

  // Reinit wins over advance because the completing flit is also a push
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flit_id <= '0;
    end else if (reinit) begin
      flit_id <= '0;
    end else if (advance && !at_max) begin
      flit_id <= flit_id + FlitIdWidth'(1);
    end
  end

endmodule : flit_id_counter

// ==== hw/slice_staging.sv ====
// Demux of push flits into staging registers and merge of the wide pop word
`timescale 1ns/100ps

module slice_staging import deser_pkg::*; #(
  parameter int PushWidth = 8,
  parameter int PopWidth  = 32,
  // 1 puts slice 0 at the most-significant end of the wide word
  parameter bit MsbFirst  = 1'b1
) (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic [flit_id_width(PopWidth/PushWidth)-1:0] flit_id,
  // Push transfer in this cycle
  input  logic                                        load,
  input  logic [PushWidth-1:0]                        push_data,
  input  logic                                        push_last,
  output logic [PopWidth-1:0]                         word
);

  localparam int Ratio       = PopWidth / PushWidth;
  localparam int FlitIdWidth = flit_id_width(Ratio);
  localparam int RatioMinus1 = Ratio - 1;

  // ------------------------------
  // Staging registers
  // ------------------------------

  // One register per slice except the last one
  // The last slice always comes straight from push_data when the word completes
  logic [Ratio-2:0][PushWidth-1:0] stage_q;

  // A flit with push_last completes the word at once, so it never needs storing
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_q <= '0;
    end else if (load && !push_last) begin
      for (int i = 0; i < RatioMinus1; i++) begin
        if (flit_id == FlitIdWidth'(i)) begin
          stage_q[i] <= push_data;
        end
      end
    end
  end

  // ------------------------------
  // Wide word merge
  // ------------------------------

  // Slices already received come from staging
  // The slice at flit_id is the live push flit
  // Slices beyond flit_id are tail slices of a short last flit and read as zero
  always_comb begin
    int slice_lsb;

    word = '0;
    for (int i = 0; i < Ratio; i++) begin
      // Slice order follows MsbFirst, bit order within a slice is kept as pushed
      slice_lsb = MsbFirst ? (RatioMinus1 - i) * PushWidth : i * PushWidth;
      if (flit_id == FlitIdWidth'(i)) begin
        word[slice_lsb +: PushWidth] = push_data;
      end else if (flit_id > FlitIdWidth'(i)) begin
        // Only reachable for i below RatioMinus1, where a register exists
        word[slice_lsb +: PushWidth] = stage_q[i];
      end
    end
  end

endmodule : slice_staging

// ==== hw/flow_deserializer.sv ====
// Flow deserializer that assembles narrow push flits into wide pop flits
`timescale 1ns/100ps

module flow_deserializer import deser_pkg::*; #(
  parameter int PushWidth = 8,
  parameter int PopWidth  = 32,
  parameter bit MsbFirst  = 1'b1
) (
  input  logic                                        clk,
  input  logic                                        rst_n,

  // Narrow push side
  input  logic                                        push_valid,
  output logic                                        push_ready,
  input  logic [PushWidth-1:0]                        push_data,
  input  logic                                        push_last,
  input  meta_t                                       push_meta,

  // Wide pop side, combinational from the push side
  input  logic                                        pop_ready,
  output logic                                        pop_valid,
  output logic [PopWidth-1:0]                         pop_data,
  output logic                                        pop_last,
  output logic [flit_id_width(PopWidth/PushWidth)-1:0] pop_dont_care,
  output meta_t                                       pop_meta
);

  localparam int Ratio       = PopWidth / PushWidth;
  localparam int FlitIdWidth = flit_id_width(Ratio);
  localparam int RatioMinus1 = Ratio - 1;

  if (Ratio == 1) begin : gen_pass_through

    // Push and pop widths match, so every flit is a complete wide flit
    assign pop_valid     = push_valid;
    assign push_ready    = pop_ready;
    assign pop_data      = push_data;
    assign pop_last      = push_last;
    assign pop_dont_care = '0;
    assign pop_meta      = push_meta;

  end else begin : gen_deserialize

    logic                   push_xfer;
    logic                   pop_xfer;
    logic                   completing;
    logic [FlitIdWidth-1:0] flit_id;

    // ------------------------------
    // Handshakes and completion
    // ------------------------------

    assign push_xfer = push_valid && push_ready;
    assign pop_xfer  = pop_valid && pop_ready;

    // The wide flit is done when the last slice arrives or the packet ends early
    assign completing = (flit_id == FlitIdWidth'(RatioMinus1)) || push_last;

    // The completing push flit and the pop flit transfer together
    assign pop_valid  = push_valid && completing;

    // Partial flits always flow into staging, the completing one waits for the pop side
    assign push_ready = !completing || pop_ready;

    // ------------------------------
    // Slice position counter
    // ------------------------------

    flit_id_counter #(
      .PushWidth (PushWidth),
      .PopWidth  (PopWidth)
    ) u_flit_id_counter (
      .clk     (clk),
      .rst_n   (rst_n),
      .advance (push_xfer && !pop_xfer),
      .reinit  (pop_xfer),
      .flit_id (flit_id)
    );

    // ------------------------------
    // Staging and merge
    // ------------------------------

    slice_staging #(
      .PushWidth (PushWidth),
      .PopWidth  (PopWidth),
      .MsbFirst  (MsbFirst)
    ) u_slice_staging (
      .clk       (clk),
      .rst_n     (rst_n),
      .flit_id   (flit_id),
      .load      (push_xfer),
      .push_data (push_data),
      .push_last (push_last),
      .word      (pop_data)
    );

    // ------------------------------
    // Pop sideband
    // ------------------------------

    assign pop_last = push_last;

    // Number of zero tail slices in a short last flit
    assign pop_dont_care = push_last ? (FlitIdWidth'(RatioMinus1) - flit_id) : '0;

    // Metadata is constant within a packet, so the completing flit carries it
    assign pop_meta = push_meta;

  end

endmodule : flow_deserializer

// ==== hw/pop_skid_register.sv ====
// Two-entry skid register that cuts the combinational wide pop path
`timescale 1ns/100ps

module pop_skid_register import deser_pkg::*; #(
  parameter int PushWidth = 8,
  parameter int PopWidth  = 32
) (
  input  logic                                        clk,
  input  logic                                        rst_n,

  // Upstream side, fed by the deserializer
  input  logic                                        in_valid,
  output logic                                        in_ready,
  input  logic [PopWidth-1:0]                         in_data,
  input  logic                                        in_last,
  input  logic [flit_id_width(PopWidth/PushWidth)-1:0] in_dont_care,
  input  meta_t                                       in_meta,

  // Downstream side, every output comes from a register
  output logic                                        out_valid,
  input  logic                                        out_ready,
  output logic [PopWidth-1:0]                         out_data,
  output logic                                        out_last,
  output logic [flit_id_width(PopWidth/PushWidth)-1:0] out_dont_care,
  output meta_t                                       out_meta
);

  localparam int DcWidth   = flit_id_width(PopWidth / PushWidth);
  localparam int WordWidth = PopWidth + 1 + DcWidth + META_WIDTH;

  skid_state_t          state_q;
  skid_state_t          state_d;
  logic                 in_xfer;
  logic                 out_xfer;
  logic [WordWidth-1:0] in_word;
  logic [WordWidth-1:0] main_q;
  logic [WordWidth-1:0] skid_q;

  assign in_xfer  = in_valid && in_ready;
  assign out_xfer = out_valid && out_ready;
  assign in_word  = {in_data, in_last, in_dont_care, in_meta};

  // ------------------------------
  // Occupancy FSM
  // ------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      SKID_EMPTY: if (in_xfer) state_d = SKID_ONE;
      // Simultaneous in and out keeps one word, which gives full throughput
      SKID_ONE: begin
        if (in_xfer && !out_xfer) begin
          state_d = SKID_TWO;
        end else if (!in_xfer && out_xfer) begin
          state_d = SKID_EMPTY;
        end
      end
      SKID_TWO: if (out_xfer) state_d = SKID_ONE;
      default: state_d = SKID_EMPTY;
    endcase
  end

  // in_ready is a flop so no path runs from out_ready back upstream
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= SKID_EMPTY;
      in_ready <= 1'b1;
    end else begin
      state_q  <= state_d;
      in_ready <= (state_d != SKID_TWO);
    end
  end

  // ------------------------------
  // Word registers
  // ------------------------------

  // Main holds the oldest word, skid catches the one that arrives under back-pressure
  always_ff @(posedge clk) begin
    if ((state_q == SKID_EMPTY && in_xfer) || (state_q == SKID_ONE && in_xfer && out_xfer)) begin
      main_q <= in_word;
    end else if (state_q == SKID_TWO && out_xfer) begin
      main_q <= skid_q;
    end
    if (state_q == SKID_ONE && in_xfer && !out_xfer) begin
      skid_q <= in_word;
    end
  end

  assign out_valid = (state_q != SKID_EMPTY);
  assign {out_data, out_last, out_dont_care, out_meta} = main_q;

endmodule : pop_skid_register

// ==== hw/deser_link_top.sv ====
// Packet link receiver that joins the flow deserializer to a pop-side skid register
`timescale 1ns/100ps

module deser_link_top import deser_pkg::*; #(
  parameter int PushWidth = 8,
  // Must be a multiple of PushWidth
  parameter int PopWidth  = 32,
  parameter bit MsbFirst  = 1'b1
) (
  input  logic                                        clk,
  input  logic                                        rst_n,

  input  logic                                        push_valid,
  output logic                                        push_ready,
  input  logic [PushWidth-1:0]                        push_data,
  input  logic                                        push_last,
  input  meta_t                                       push_meta,

  input  logic                                        pop_ready,
  output logic                                        pop_valid,
  output logic [PopWidth-1:0]                         pop_data,
  output logic                                        pop_last,
  output logic [flit_id_width(PopWidth/PushWidth)-1:0] pop_dont_care,
  output meta_t                                       pop_meta
);

  localparam int DcWidth = flit_id_width(PopWidth / PushWidth);

  // Wide flits between the deserializer and the skid register
  logic                des_valid;
  logic                des_ready;
  logic [PopWidth-1:0] des_data;
  logic                des_last;
  logic [DcWidth-1:0]  des_dont_care;
  meta_t               des_meta;

  flow_deserializer #(
    .PushWidth (PushWidth),
    .PopWidth  (PopWidth),
    .MsbFirst  (MsbFirst)
  ) u_deser (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_valid    (push_valid),
    .push_ready    (push_ready),
    .push_data     (push_data),
    .push_last     (push_last),
    .push_meta     (push_meta),
    .pop_ready     (des_ready),
    .pop_valid     (des_valid),
    .pop_data      (des_data),
    .pop_last      (des_last),
    .pop_dont_care (des_dont_care),
    .pop_meta      (des_meta)
  );

  // Registers the wide side, adding one cycle of latency
  pop_skid_register #(
    .PushWidth (PushWidth),
    .PopWidth  (PopWidth)
  ) u_skid (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (des_valid),
    .in_ready      (des_ready),
    .in_data       (des_data),
    .in_last       (des_last),
    .in_dont_care  (des_dont_care),
    .in_meta       (des_meta),
    .out_valid     (pop_valid),
    .out_ready     (pop_ready),
    .out_data      (pop_data),
    .out_last      (pop_last),
    .out_dont_care (pop_dont_care),
    .out_meta      (pop_meta)
  );

endmodule : deser_link_top

// ==== testbench/tb_deser_link.sv ====
// Self-checking testbench for the narrow-to-wide packet link receiver
`timescale 1ns/100ps

module tb_deser_link import deser_pkg::*; #(
  parameter bit MsbFirst = 1'b1
);

  localparam int PushWidth = 8;
  localparam int PopWidth  = 32;
  localparam int Ratio     = PopWidth / PushWidth;
  localparam int DcWidth   = flit_id_width(Ratio);
  localparam int NumFull   = 4;
  localparam int NumShort  = 6;
  localparam int NumBp     = 24;
  localparam int NumPkts   = NumFull + NumShort + NumBp;

  logic                 clk;
  logic                 rst_n;
  logic                 push_valid;
  logic                 push_ready;
  logic [PushWidth-1:0] push_data;
  logic                 push_last;
  meta_t                push_meta;
  logic                 pop_ready;
  logic                 pop_valid;
  logic [PopWidth-1:0]  pop_data;
  logic                 pop_last;
  logic [DcWidth-1:0]   pop_dont_care;
  meta_t                pop_meta;

  // Marks the push flit that should complete a wide word, as the model sees it
  logic        push_completes;
  // Set while pop_ready is held high and the skid started empty
  logic        ready_held;
  logic        random_ready;
  logic [1:0]  duty;
  logic [31:0] rng_data;
  logic [31:0] rng_ready;
  string       test_name;
  int          errors;
  int          errors_at_open;
  int          tests_passed;
  int          tests_failed;
  int          cycles;
  int          cycle_limit;
  int          pkt_len [NumPkts];

  // Expected wide words in pop order
  logic [PopWidth-1:0] exp_data [$];
  logic                exp_last [$];
  logic [DcWidth-1:0]  exp_dc [$];
  meta_t               exp_meta [$];

  deser_link_top #(
    .PushWidth (PushWidth),
    .PopWidth  (PopWidth),
    .MsbFirst  (MsbFirst)
  ) u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_valid    (push_valid),
    .push_ready    (push_ready),
    .push_data     (push_data),
    .push_last     (push_last),
    .push_meta     (push_meta),
    .pop_ready     (pop_ready),
    .pop_valid     (pop_valid),
    .pop_data      (pop_data),
    .pop_last      (pop_last),
    .pop_dont_care (pop_dont_care),
    .pop_meta      (pop_meta)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift_step(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic show_mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("FAILED %s: %s expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
    errors++;
  endtask

  task automatic open_test(input string name);
    test_name      = name;
    errors_at_open = errors;
  endtask

  task automatic close_test();
    if (errors == errors_at_open) begin
      $display("[PASS] %s", test_name);
      tests_passed++;
    end else begin
      $display("[FAIL] %s with %0d errors", test_name, errors - errors_at_open);
      tests_failed++;
    end
  endtask

  // ------------------------------
  // Stimulus and reference model
  // ------------------------------

  // Slice s of a wide word sits at the top when MsbFirst is set, else at the bottom
  // Slices past the end of a short packet stay zero
  // Every flit carries its own metadata, and a word keeps the one of its completing flit
  task automatic send_packet(input int len);
    logic [PushWidth-1:0] bytes [$];
    meta_t                metas [$];
    logic [PopWidth-1:0]  word;
    int                   pos;
    int                   left;
    for (int k = 0; k < len; k++) begin
      rng_data = xorshift_step(rng_data);
      bytes.push_back(rng_data[PushWidth-1:0]);
      metas.push_back(rng_data[PushWidth+META_WIDTH-1:PushWidth]);
    end
    for (int w = 0; w * Ratio < len; w++) begin
      word = '0;
      left = len - w * Ratio;
      for (int s = 0; s < Ratio && s < left; s++) begin
        pos = MsbFirst ? (Ratio - 1 - s) * PushWidth : s * PushWidth;
        word[pos +: PushWidth] = bytes[w * Ratio + s];
      end
      exp_data.push_back(word);
      exp_last.push_back(left <= Ratio);
      exp_dc.push_back((left < Ratio) ? DcWidth'(Ratio - left) : '0);
      exp_meta.push_back(metas[w * Ratio + ((left < Ratio) ? left : Ratio) - 1]);
    end
    for (int k = 0; k < len; k++) begin
      push_valid     = 1'b1;
      push_data      = bytes[k];
      push_last      = (k == len - 1);
      push_meta      = metas[k];
      push_completes = (k % Ratio == Ratio - 1) || (k == len - 1);
      // push_ready is combinational, so it is settled by the falling edge
      @(negedge clk);
      while (!push_ready) @(negedge clk);
      @(posedge clk);
      #1;
    end
    push_valid     = 1'b0;
    push_last      = 1'b0;
    push_completes = 1'b0;
  endtask

  // Returns one step after the last expected word has left the pop port
  task automatic wait_drain();
    while (exp_data.size() != 0) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  // Random back-pressure, with a duty cycle that changes now and then
  always @(posedge clk) begin
    #1;
    if (random_ready) begin
      rng_ready = xorshift_step(rng_ready);
      if (rng_ready[7:4] == 4'd0) duty = 2'd2 + {1'b0, rng_ready[8]};
      pop_ready = (rng_ready[1:0] < duty);
    end else begin
      pop_ready = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles in test %s, the DUT stopped moving words", cycles,
               test_name);
      $display("Test failures found");
      $finish;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------

  // Pop transfers are judged at the falling edge, where all outputs have settled
  always @(negedge clk) begin
    if (rst_n && pop_valid && pop_ready) begin
      if (exp_data.size() == 0) begin
        $display("Error in %s: a word was popped that the model never expected", test_name);
        errors++;
      end else begin
        assert (pop_data == exp_data[0])
          else show_mismatch("pop_data", exp_data[0], pop_data);
        assert (pop_last == exp_last[0])
          else show_mismatch("pop_last", 32'(exp_last[0]), 32'(pop_last));
        assert (pop_dont_care == exp_dc[0])
          else show_mismatch("pop_dont_care", 32'(exp_dc[0]), 32'(pop_dont_care));
        assert (pop_meta == exp_meta[0])
          else show_mismatch("pop_meta", 32'(exp_meta[0]), 32'(pop_meta));
        void'(exp_data.pop_front());
        void'(exp_last.pop_front());
        void'(exp_dc.pop_front());
        void'(exp_meta.pop_front());
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !pop_valid)
    else begin
      $display("Error in %s: pop_valid was high during reset", test_name);
      errors++;
    end

  a_reset_release: assert property (@(posedge clk) $rose(rst_n) |-> !pop_valid && push_ready)
    else begin
      $display("Error in %s: wrong handshake state just after reset release", test_name);
      errors++;
    end

  // With pop_ready held high, a completing push shows up on the pop port one cycle later
  a_latency_hit: assert property (@(posedge clk) disable iff (!rst_n)
    ready_held && push_valid && push_ready && push_completes |=> pop_valid)
    else begin
      $display("Error in %s: pop_valid missing one cycle after a completing push", test_name);
      errors++;
    end

  a_latency_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    ready_held && !(push_valid && push_ready && push_completes) |=> !pop_valid)
    else begin
      $display("Error in %s: pop_valid high without a completing push before it", test_name);
      errors++;
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data) && $stable(pop_last)
                                && $stable(pop_dont_care) && $stable(pop_meta))
    else begin
      $display("Error in %s: pop outputs changed while stalled by pop_ready", test_name);
      errors++;
    end

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    int total;
    clk = 1'b0;
    rst_n = 1'b0;
    push_valid = 1'b0;
    push_data = '0;
    push_last = 1'b0;
    push_meta = '0;
    push_completes = 1'b0;
    pop_ready = 1'b1;
    ready_held = 1'b0;
    random_ready = 1'b0;
    duty = 2'd2;
    rng_data = 32'd81769;
    rng_ready = xorshift_step(32'd81769);
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycles = 0;
    total = 0;
    // Full packets first, then short ones that end mid-word, then random ones
    for (int p = 0; p < NumPkts; p++) begin
      if (p < NumFull) begin
        pkt_len[p] = 2 * Ratio;
      end else begin
        pkt_len[p] = Ratio;
        while (p < NumFull + NumShort && pkt_len[p] % Ratio == 0 || pkt_len[p] == Ratio) begin
          rng_data = xorshift_step(rng_data);
          pkt_len[p] = 1 + int'(rng_data % 32'd9);
          if (p >= NumFull + NumShort) break;
        end
      end
      total += pkt_len[p];
    end
    cycle_limit = total * 4 + 200;
    open_test("reset");
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    close_test();

    open_test("full_packets");
    ready_held = 1'b1;
    for (int p = 0; p < NumFull; p++) send_packet(pkt_len[p]);
    wait_drain();
    close_test();

    open_test("short_last");
    for (int p = NumFull; p < NumFull + NumShort; p++) send_packet(pkt_len[p]);
    wait_drain();
    close_test();

    // Mode flags change at the falling edge so the ready driver sees them cleanly
    @(negedge clk);
    ready_held = 1'b0;
    random_ready = 1'b1;
    open_test("back_pressure");
    @(posedge clk);
    #1;
    for (int p = NumFull + NumShort; p < NumPkts; p++) send_packet(pkt_len[p]);
    wait_drain();
    close_test();

    $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : tb_deser_link

// ==== flist.f ====
hw/deser_pkg.sv
hw/flit_id_counter.sv
hw/slice_staging.sv
hw/flow_deserializer.sv
hw/pop_skid_register.sv
hw/deser_link_top.sv
testbench/tb_deser_link.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the link receiver testbench with Verilator for both slice orders
set -e

cd "$(dirname "$0")"

for msb in 0 1; do
  verilator --binary --timing --assert \
    -f flist.f \
    --top-module tb_deser_link \
    -GMsbFirst=$msb \
    -Mdir obj_msb$msb \
    -o sim
  ./obj_msb$msb/sim > sim_msb$msb.log 2>&1 || true
  cat sim_msb$msb.log
  if ! grep -q "All tests passed!" sim_msb$msb.log; then
    echo "Simulation with MsbFirst=$msb did not pass"
    exit 1
  fi
done

echo "Both MsbFirst runs passed"
